// File: Makefile
VERILATOR ?= verilator
TOP       ?= basics_int_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim_$(TOP)
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR SIM_BIN LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/basics_cfg_pkg.sv
`default_nettype none

`include "basics_defines.svh"

package basics_cfg_pkg;

	typedef enum logic [2:0] {
		PARAM_NONE,
		PARAM_I2C_SPEED,
		PARAM_I2C_ADDR,
		PARAM_GPIO_LEVEL,
		PARAM_GPIO_DIR,
		PARAM_GPIO_READ
	} param_sel_t;

	typedef logic [`BYTE_W-1:0] i2c_speed_t;
	typedef logic [`I2C_ADDR_W-1:0] i2c_addr_t;
	typedef logic [`GPIO_W-1:0] gpio_word_t;

	// Query values are right-aligned in this word
	typedef logic [`GPIO_W-1:0] param_word_t;

	// Value length in bytes for each selector
	function automatic logic [1:0] param_len(param_sel_t sel);
		case (sel)
			PARAM_I2C_SPEED: return 2'd1;
			PARAM_I2C_ADDR: return 2'd2;
			PARAM_GPIO_LEVEL, PARAM_GPIO_DIR, PARAM_GPIO_READ: return 2'd3;
			default: return 2'd0;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: hw/basics_int.sv
`timescale 1ns/1ps
`default_nettype none

module basics_int (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          generate_nak,
	input  basics_proto_pkg::msg_byte_t   ma_data,
	input  logic                          ma_data_valid,
	input  logic                          ma_frame_valid,
	input  basics_proto_pkg::fifo_ptr_t   sl_addr,
	output basics_proto_pkg::fifo_ptr_t   sl_tail,
	output basics_proto_pkg::fifo_entry_t sl_data,
	input  logic                          sl_latch_tail,
	output logic                          sl_arb_request,
	input  basics_cfg_pkg::gpio_word_t    gpio_read,
	output basics_cfg_pkg::i2c_speed_t    i2c_speed,
	output basics_cfg_pkg::i2c_addr_t     i2c_addr,
	output basics_cfg_pkg::gpio_word_t    gpio_level,
	output basics_cfg_pkg::gpio_word_t    gpio_direction
);

	// Decoder to settings
	basics_cfg_pkg::param_sel_t  param_sel;
	logic                        param_shift;
	basics_proto_pkg::msg_byte_t param_data;
	logic                        param_commit;
	basics_cfg_pkg::param_word_t query_word;

	// Decoder to response buffer
	basics_proto_pkg::msg_byte_t msg_data;
	logic                        msg_latch;
	logic                        msg_frame_valid;

	command_decoder u_decoder (
		.clk            (clk),
		.rst            (rst),
		.generate_nak   (generate_nak),
		.ma_data        (ma_data),
		.ma_data_valid  (ma_data_valid),
		.ma_frame_valid (ma_frame_valid),
		.sl_arb_request (sl_arb_request),
		.query_word     (query_word),
		.param_sel      (param_sel),
		.param_shift    (param_shift),
		.param_data     (param_data),
		.param_commit   (param_commit),
		.msg_data       (msg_data),
		.msg_latch      (msg_latch),
		.msg_frame_valid(msg_frame_valid)
	);

	settings_regs u_settings (
		.clk           (clk),
		.rst           (rst),
		.param_sel     (param_sel),
		.param_shift   (param_shift),
		.param_data    (param_data),
		.param_commit  (param_commit),
		.gpio_read     (gpio_read),
		.query_word    (query_word),
		.i2c_speed     (i2c_speed),
		.i2c_addr      (i2c_addr),
		.gpio_level    (gpio_level),
		.gpio_direction(gpio_direction)
	);

	message_fifo u_fifo (
		.clk            (clk),
		.rst            (rst),
		.msg_data       (msg_data),
		.msg_latch      (msg_latch),
		.msg_frame_valid(msg_frame_valid),
		.sl_addr        (sl_addr),
		.sl_data        (sl_data),
		.sl_tail        (sl_tail),
		.sl_latch_tail  (sl_latch_tail),
		.sl_arb_request (sl_arb_request)
	);

endmodule

`default_nettype wire

// File: hw/basics_proto_pkg.sv
`default_nettype none

`include "basics_defines.svh"

package basics_proto_pkg;

	typedef logic [`BYTE_W-1:0] msg_byte_t;
	typedef logic [`BYTE_W-1:0] eid_t;

	// End-of-frame flag sits above the data byte
	typedef logic [`BYTE_W:0] fifo_entry_t;
	typedef logic [`PTR_W-1:0] fifo_ptr_t;

	typedef enum logic [3:0] {
		DEC_IDLE,
		DEC_EID,
		DEC_LEN,
		DEC_VER,
		DEC_SEL,
		DEC_QLOAD,
		DEC_SET,
		DEC_RESP,
		DEC_WAIT_HI,
		DEC_WAIT_LO
	} dec_state_t;

endpackage

`default_nettype wire

// File: hw/command_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "basics_defines.svh"

module command_decoder (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         generate_nak,
	input  basics_proto_pkg::msg_byte_t  ma_data,
	input  logic                         ma_data_valid,
	input  logic                         ma_frame_valid,
	input  logic                         sl_arb_request,
	input  basics_cfg_pkg::param_word_t  query_word,
	output basics_cfg_pkg::param_sel_t   param_sel,
	output logic                         param_shift,
	output basics_proto_pkg::msg_byte_t  param_data,
	output logic                         param_commit,
	output basics_proto_pkg::msg_byte_t  msg_data,
	output logic                         msg_latch,
	output logic                         msg_frame_valid
);

	basics_proto_pkg::dec_state_t state;

	logic                        frame_valid_d;
	logic                        nak_req;
	logic                        ver_cnt;
	logic [1:0]                  set_cnt;
	logic [2:0]                  byte_cnt;
	logic                        commit_pending;

	basics_proto_pkg::msg_byte_t cmd;
	basics_proto_pkg::eid_t      eid;
	basics_proto_pkg::msg_byte_t ver_hi;
	basics_proto_pkg::msg_byte_t resp_code;
	logic [1:0]                  resp_len;
	basics_cfg_pkg::param_word_t staging;

	basics_cfg_pkg::param_sel_t  sel_dec;
	logic                        frame_start;
	logic                        cmd_known;
	logic                        cmd_set;
	logic                        cmd_i2c;
	logic                        ver_match;
	logic                        resp_last;

	// Command byte comes with the rising edge of the frame
	assign frame_start = ma_frame_valid && !frame_valid_d && ma_data_valid;
	assign cmd_known = (ma_data == `CMD_VERSION) || (ma_data == `CMD_I2C_QUERY) ||
		(ma_data == `CMD_I2C_SET) || (ma_data == `CMD_GPIO_QUERY) ||
		(ma_data == `CMD_GPIO_SET);
	assign cmd_set = (cmd == `CMD_I2C_SET) || (cmd == `CMD_GPIO_SET);
	assign cmd_i2c = (cmd == `CMD_I2C_QUERY) || (cmd == `CMD_I2C_SET);
	assign ver_match = ({ver_hi, ma_data} == {`VERSION_MAJOR, `VERSION_MINOR});
	assign resp_last = (byte_cnt == 3'd2 + {1'b0, resp_len});

	// Map the selector byte to a setting
	// On a query "l" reads the pins
	always_comb begin
		sel_dec = basics_cfg_pkg::PARAM_NONE;
		if (cmd_i2c) begin
			if (ma_data == `SEL_SPEED)
				sel_dec = basics_cfg_pkg::PARAM_I2C_SPEED;
			else if (ma_data == `SEL_ADDR)
				sel_dec = basics_cfg_pkg::PARAM_I2C_ADDR;
		end else if (ma_data == `SEL_LEVEL) begin
			if (cmd_set)
				sel_dec = basics_cfg_pkg::PARAM_GPIO_LEVEL;
			else
				sel_dec = basics_cfg_pkg::PARAM_GPIO_READ;
		end else if (ma_data == `SEL_DIR) begin
			sel_dec = basics_cfg_pkg::PARAM_GPIO_DIR;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= basics_proto_pkg::DEC_IDLE;
			frame_valid_d <= 1'b0;
			nak_req <= 1'b0;
			ver_cnt <= 1'b0;
			set_cnt <= 2'd0;
			byte_cnt <= 3'd0;
			commit_pending <= 1'b0;
			param_sel <= basics_cfg_pkg::PARAM_NONE;
		end else begin
			frame_valid_d <= ma_frame_valid;
			byte_cnt <= (state == basics_proto_pkg::DEC_RESP) ? byte_cnt + 3'd1 : 3'd0;
			case (state)
				basics_proto_pkg::DEC_IDLE: begin
					ver_cnt <= 1'b0;
					commit_pending <= 1'b0;
					// EID of an immediate NAK is the next data byte
					if (generate_nak) begin
						nak_req <= 1'b1;
						state <= basics_proto_pkg::DEC_EID;
					end else if (frame_start && cmd_known) begin
						nak_req <= 1'b0;
						param_sel <= basics_cfg_pkg::PARAM_NONE;
						state <= basics_proto_pkg::DEC_EID;
					end
				end
				basics_proto_pkg::DEC_EID: begin
					if (ma_data_valid) begin
						if (nak_req)
							state <= basics_proto_pkg::DEC_RESP;
						else
							state <= basics_proto_pkg::DEC_LEN;
					end
				end
				basics_proto_pkg::DEC_LEN: begin
					if (ma_data_valid) begin
						if (cmd == `CMD_VERSION)
							state <= basics_proto_pkg::DEC_VER;
						else
							state <= basics_proto_pkg::DEC_SEL;
					end
				end
				basics_proto_pkg::DEC_VER: begin
					if (ma_data_valid) begin
						ver_cnt <= 1'b1;
						if (ver_cnt)
							state <= basics_proto_pkg::DEC_RESP;
					end
				end
				basics_proto_pkg::DEC_SEL: begin
					if (ma_data_valid) begin
						param_sel <= sel_dec;
						set_cnt <= basics_cfg_pkg::param_len(sel_dec);
						if (sel_dec == basics_cfg_pkg::PARAM_NONE) begin
							state <= basics_proto_pkg::DEC_RESP;
						end else if (cmd_set) begin
							commit_pending <= sel_dec inside {basics_cfg_pkg::PARAM_GPIO_LEVEL,
								basics_cfg_pkg::PARAM_GPIO_DIR};
							state <= basics_proto_pkg::DEC_SET;
						end else begin
							state <= basics_proto_pkg::DEC_QLOAD;
						end
					end
				end
				// query_word follows param_sel one cycle later
				basics_proto_pkg::DEC_QLOAD: state <= basics_proto_pkg::DEC_RESP;
				basics_proto_pkg::DEC_SET: begin
					if (ma_data_valid) begin
						set_cnt <= set_cnt - 2'd1;
						if (set_cnt == 2'd1)
							state <= basics_proto_pkg::DEC_RESP;
					end
				end
				basics_proto_pkg::DEC_RESP: begin
					if (resp_last) begin
						if (commit_pending)
							state <= basics_proto_pkg::DEC_WAIT_HI;
						else
							state <= basics_proto_pkg::DEC_IDLE;
					end
				end
				// GPIO takes effect once the ACK has been read out
				basics_proto_pkg::DEC_WAIT_HI: begin
					if (sl_arb_request)
						state <= basics_proto_pkg::DEC_WAIT_LO;
				end
				basics_proto_pkg::DEC_WAIT_LO: begin
					if (!sl_arb_request)
						state <= basics_proto_pkg::DEC_IDLE;
				end
				default: state <= basics_proto_pkg::DEC_IDLE;
			endcase
		end
	end

	// Response header and payload
	always_ff @(posedge clk) begin
		case (state)
			basics_proto_pkg::DEC_IDLE: begin
				if (frame_start)
					cmd <= ma_data;
			end
			basics_proto_pkg::DEC_EID: begin
				if (ma_data_valid) begin
					eid <= ma_data;
					resp_code <= `RESP_NAK;
					resp_len <= 2'd0;
				end
			end
			basics_proto_pkg::DEC_VER: begin
				if (ma_data_valid) begin
					ver_hi <= ma_data;
					resp_code <= ver_match ? `RESP_ACK : `RESP_NAK;
					resp_len <= ver_match ? 2'd0 : 2'd2;
					staging <= {`VERSION_MAJOR, `VERSION_MINOR, 8'h00};
				end
			end
			basics_proto_pkg::DEC_SEL: begin
				if (ma_data_valid) begin
					resp_code <= (sel_dec == basics_cfg_pkg::PARAM_NONE) ? `RESP_NAK : `RESP_ACK;
					resp_len <= 2'd0;
				end
			end
			basics_proto_pkg::DEC_QLOAD: begin
				// Left-align so the top byte goes out first
				staging <= query_word << (`BYTE_W * (2'd3 - basics_cfg_pkg::param_len(param_sel)));
				resp_len <= basics_cfg_pkg::param_len(param_sel);
			end
			basics_proto_pkg::DEC_RESP: begin
				if (byte_cnt >= 3'd3)
					staging <= staging << `BYTE_W;
			end
			default: ;
		endcase
	end

	always_comb begin
		case (byte_cnt)
			3'd0: msg_data = resp_code;
			3'd1: msg_data = eid;
			3'd2: msg_data = basics_proto_pkg::msg_byte_t'(resp_len);
			default: msg_data = staging[`GPIO_W-1 -: `BYTE_W];
		endcase
	end

	assign msg_frame_valid = (state == basics_proto_pkg::DEC_RESP);
	assign msg_latch = (state == basics_proto_pkg::DEC_RESP);

	assign param_shift = (state == basics_proto_pkg::DEC_SET) && ma_data_valid;
	assign param_data = ma_data;
	assign param_commit = (state == basics_proto_pkg::DEC_WAIT_LO) && !sl_arb_request;

	// A set only reaches the settings after a valid selector
	a_shift_sel: assert property (@(posedge clk) disable iff (rst)
		param_shift |-> param_sel != basics_cfg_pkg::PARAM_NONE);

endmodule

`default_nettype wire

// File: hw/message_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "basics_defines.svh"

module message_fifo #(
	parameter int DEPTH_LOG2 = `FIFO_DEPTH_LOG2
) (
	input  logic                          clk,
	input  logic                          rst,
	input  basics_proto_pkg::msg_byte_t   msg_data,
	input  logic                          msg_latch,
	input  logic                          msg_frame_valid,
	input  basics_proto_pkg::fifo_ptr_t   sl_addr,
	output basics_proto_pkg::fifo_entry_t sl_data,
	output basics_proto_pkg::fifo_ptr_t   sl_tail,
	input  logic                          sl_latch_tail,
	output logic                          sl_arb_request
);

	basics_proto_pkg::fifo_entry_t mem [2**DEPTH_LOG2];

	// head is the oldest unreleased entry, wr_ptr runs ahead of the tail
	basics_proto_pkg::fifo_ptr_t head;
	basics_proto_pkg::fifo_ptr_t wr_ptr;
	basics_proto_pkg::fifo_ptr_t last_ptr;
	basics_proto_pkg::msg_byte_t last_byte;
	logic                        frame_valid_d;
	logic                        frame_close;
	logic                        full;
	logic                        wr_en;

	assign frame_close = frame_valid_d && !msg_frame_valid;
	assign full = (basics_proto_pkg::fifo_ptr_t'(wr_ptr - head) ==
		basics_proto_pkg::fifo_ptr_t'(2**DEPTH_LOG2));
	assign wr_en = msg_latch && !full;
	assign last_ptr = wr_ptr - 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			wr_ptr <= '0;
			sl_tail <= '0;
			frame_valid_d <= 1'b0;
		end else begin
			frame_valid_d <= msg_frame_valid;
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (frame_close)
				sl_tail <= wr_ptr;
			if (sl_latch_tail)
				head <= sl_tail;
		end
	end

	// Latch and close never share a cycle, so one write port does
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr[DEPTH_LOG2-1:0]] <= {1'b0, msg_data};
			last_byte <= msg_data;
		end else if (frame_close) begin
			mem[last_ptr[DEPTH_LOG2-1:0]] <= {1'b1, last_byte};
		end
	end

	always_ff @(posedge clk) begin
		sl_data <= mem[sl_addr[DEPTH_LOG2-1:0]];
	end

	assign sl_arb_request = (head != sl_tail);

	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		msg_latch |-> !full);

	a_release_valid: assert property (@(posedge clk) disable iff (rst)
		sl_latch_tail |-> sl_arb_request);

endmodule

`default_nettype wire

// File: hw/settings_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "basics_defines.svh"

module settings_regs (
	input  logic                         clk,
	input  logic                         rst,
	input  basics_cfg_pkg::param_sel_t   param_sel,
	input  logic                         param_shift,
	input  basics_proto_pkg::msg_byte_t  param_data,
	input  logic                         param_commit,
	input  basics_cfg_pkg::gpio_word_t   gpio_read,
	output basics_cfg_pkg::param_word_t  query_word,
	output basics_cfg_pkg::i2c_speed_t   i2c_speed,
	output basics_cfg_pkg::i2c_addr_t    i2c_addr,
	output basics_cfg_pkg::gpio_word_t   gpio_level,
	output basics_cfg_pkg::gpio_word_t   gpio_direction
);

	// Staged GPIO words, copied out on commit
	basics_cfg_pkg::gpio_word_t level_stage;
	basics_cfg_pkg::gpio_word_t dir_stage;

	always_ff @(posedge clk) begin
		if (rst) begin
			i2c_speed <= `I2C_SPEED_RST;
			i2c_addr <= `I2C_ADDR_RST;
			gpio_level <= '0;
			gpio_direction <= '0;
		end else begin
			// I2C settings follow each value byte
			if (param_shift) begin
				case (param_sel)
					basics_cfg_pkg::PARAM_I2C_SPEED: i2c_speed <= param_data;
					basics_cfg_pkg::PARAM_I2C_ADDR:
						i2c_addr <= {i2c_addr[`I2C_ADDR_W-`BYTE_W-1:0], param_data};
					default: ;
				endcase
			end
			if (param_commit) begin
				case (param_sel)
					basics_cfg_pkg::PARAM_GPIO_LEVEL: gpio_level <= level_stage;
					basics_cfg_pkg::PARAM_GPIO_DIR: gpio_direction <= dir_stage;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (param_shift && param_sel == basics_cfg_pkg::PARAM_GPIO_LEVEL)
			level_stage <= {level_stage[`GPIO_W-`BYTE_W-1:0], param_data};
		if (param_shift && param_sel == basics_cfg_pkg::PARAM_GPIO_DIR)
			dir_stage <= {dir_stage[`GPIO_W-`BYTE_W-1:0], param_data};
	end

	always_comb begin
		case (param_sel)
			basics_cfg_pkg::PARAM_I2C_SPEED: query_word = basics_cfg_pkg::param_word_t'(i2c_speed);
			basics_cfg_pkg::PARAM_I2C_ADDR: query_word = basics_cfg_pkg::param_word_t'(i2c_addr);
			basics_cfg_pkg::PARAM_GPIO_LEVEL: query_word = gpio_level;
			basics_cfg_pkg::PARAM_GPIO_DIR: query_word = gpio_direction;
			basics_cfg_pkg::PARAM_GPIO_READ: query_word = gpio_read;
			default: query_word = '0;
		endcase
	end

	// Only GPIO words are staged
	a_commit_gpio: assert property (@(posedge clk) disable iff (rst)
		param_commit |-> param_sel inside {basics_cfg_pkg::PARAM_GPIO_LEVEL,
			basics_cfg_pkg::PARAM_GPIO_DIR});

endmodule

`default_nettype wire

// File: include/basics_defines.svh
`ifndef BASICS_DEFINES_SVH
`define BASICS_DEFINES_SVH

// Bus and buffer widths
`define BYTE_W          8
`define PTR_W           9
`define FIFO_DEPTH_LOG2 5

// Setting widths
`define GPIO_W          24
`define I2C_ADDR_W      16

// Version reported by this block
`define VERSION_MAJOR   8'h00
`define VERSION_MINOR   8'h04

// Request command codes
`define CMD_VERSION     8'h76
`define CMD_I2C_QUERY   8'h49
`define CMD_I2C_SET     8'h69
`define CMD_GPIO_QUERY  8'h47
`define CMD_GPIO_SET    8'h67

// Parameter selectors "c" "a" "l" "d"
`define SEL_SPEED       8'h63
`define SEL_ADDR        8'h61
`define SEL_LEVEL       8'h6C
`define SEL_DIR         8'h64

// Response codes
`define RESP_ACK        8'h00
`define RESP_NAK        8'h01

// Settings after reset
`define I2C_SPEED_RST   8'd99
`define I2C_ADDR_RST    16'hFFFF

`endif

// File: project.f
+incdir+include
hw/basics_proto_pkg.sv
hw/basics_cfg_pkg.sv
hw/command_decoder.sv
hw/settings_regs.sv
hw/message_fifo.sv
hw/basics_int.sv
tests/basics_int_tb.sv

// File: tests/basics_int_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "basics_defines.svh"

module basics_int_tb;

	localparam int CLK_PERIOD = 40;
	localparam int MAX_ROWS = 20;
	localparam int RESP_WAIT = 60;
	localparam int SILENT_CYCLES = 20;
	localparam int SETTLE_CYCLES = 4;

	logic                          clk;
	logic                          rst;
	logic                          generate_nak;
	basics_proto_pkg::msg_byte_t   ma_data;
	logic                          ma_data_valid;
	logic                          ma_frame_valid;
	basics_proto_pkg::fifo_ptr_t   sl_addr;
	basics_proto_pkg::fifo_ptr_t   sl_tail;
	basics_proto_pkg::fifo_entry_t sl_data;
	logic                          sl_latch_tail;
	logic                          sl_arb_request;
	basics_cfg_pkg::gpio_word_t    gpio_read;
	basics_cfg_pkg::i2c_speed_t    i2c_speed;
	basics_cfg_pkg::i2c_addr_t     i2c_addr;
	basics_cfg_pkg::gpio_word_t    gpio_level;
	basics_cfg_pkg::gpio_word_t    gpio_direction;

	// Stimulus table with byte 0 in the top byte of each vector
	logic        row_nak [MAX_ROWS];
	int          req_count [MAX_ROWS];
	logic [55:0] req_bytes [MAX_ROWS];
	int          rsp_count [MAX_ROWS];
	logic [47:0] rsp_bytes [MAX_ROWS];
	logic [23:0] row_pins [MAX_ROWS];
	logic [7:0]  exp_speed [MAX_ROWS];
	logic [15:0] exp_addr [MAX_ROWS];
	logic [23:0] exp_level [MAX_ROWS];
	logic [23:0] exp_dir [MAX_ROWS];
	int          row_total;
	logic        table_ready;

	// Expected settings while the table is built
	logic [7:0]  model_speed;
	logic [15:0] model_addr;
	logic [23:0] model_level;
	logic [23:0] model_dir;
	logic [23:0] pins;
	logic [31:0] rnd;

	basics_proto_pkg::fifo_ptr_t rd_ptr;

	basics_int uut (
		.clk            (clk),
		.rst            (rst),
		.generate_nak   (generate_nak),
		.ma_data        (ma_data),
		.ma_data_valid  (ma_data_valid),
		.ma_frame_valid (ma_frame_valid),
		.sl_addr        (sl_addr),
		.sl_tail        (sl_tail),
		.sl_data        (sl_data),
		.sl_latch_tail  (sl_latch_tail),
		.sl_arb_request (sl_arb_request),
		.gpio_read      (gpio_read),
		.i2c_speed      (i2c_speed),
		.i2c_addr       (i2c_addr),
		.gpio_level     (gpio_level),
		.gpio_direction (gpio_direction)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			stop_run($sformatf("mismatch at %0t ns: %s is 'h%0h, expected 'h%0h",
				$time, name, got, exp));
		end
	endtask

	task automatic add_row(input logic nak, input int n_req, input logic [55:0] req,
		input int n_rsp, input logic [47:0] rsp);
		row_nak[row_total] = nak;
		req_count[row_total] = n_req;
		req_bytes[row_total] = req;
		rsp_count[row_total] = n_rsp;
		rsp_bytes[row_total] = rsp;
		row_pins[row_total] = pins;
		exp_speed[row_total] = model_speed;
		exp_addr[row_total] = model_addr;
		exp_level[row_total] = model_level;
		exp_dir[row_total] = model_dir;
		row_total++;
		// Fresh pin state for the next row
		rnd = $urandom;
		pins = rnd[23:0];
	endtask

	task automatic build_table();
		model_speed = `I2C_SPEED_RST;
		model_addr = `I2C_ADDR_RST;
		model_level = 24'h0;
		model_dir = 24'h0;
		rnd = $urandom;
		pins = rnd[23:0];
		// Version match, then a mismatch that reports our own version
		add_row(0, 5, {`CMD_VERSION, 8'h11, 8'h02, 8'h00, 8'h04, 16'h0},
			3, {`RESP_ACK, 8'h11, 8'h00, 24'h0});
		add_row(0, 5, {`CMD_VERSION, 8'h12, 8'h02, 8'h00, 8'h03, 16'h0},
			5, {`RESP_NAK, 8'h12, 8'h02, 8'h00, 8'h04, 8'h0});
		// I2C set applies per byte
		model_speed = 8'h2A;
		add_row(0, 5, {`CMD_I2C_SET, 8'h13, 8'h02, `SEL_SPEED, 8'h2A, 16'h0},
			3, {`RESP_ACK, 8'h13, 8'h00, 24'h0});
		model_addr = 16'h1234;
		add_row(0, 6, {`CMD_I2C_SET, 8'h14, 8'h03, `SEL_ADDR, 8'h12, 8'h34, 8'h0},
			3, {`RESP_ACK, 8'h14, 8'h00, 24'h0});
		add_row(0, 4, {`CMD_I2C_QUERY, 8'h15, 8'h01, `SEL_SPEED, 24'h0},
			4, {`RESP_ACK, 8'h15, 8'h01, 8'h2A, 16'h0});
		add_row(0, 4, {`CMD_I2C_QUERY, 8'h16, 8'h01, `SEL_ADDR, 24'h0},
			5, {`RESP_ACK, 8'h16, 8'h02, 8'h12, 8'h34, 8'h0});
		// GPIO set is staged until the ACK is released
		model_dir = 24'hA55AC3;
		add_row(0, 7, {`CMD_GPIO_SET, 8'h17, 8'h04, `SEL_DIR, 24'hA55AC3},
			3, {`RESP_ACK, 8'h17, 8'h00, 24'h0});
		model_level = 24'h0FF081;
		add_row(0, 7, {`CMD_GPIO_SET, 8'h18, 8'h04, `SEL_LEVEL, 24'h0FF081},
			3, {`RESP_ACK, 8'h18, 8'h00, 24'h0});
		add_row(0, 4, {`CMD_GPIO_QUERY, 8'h19, 8'h01, `SEL_DIR, 24'h0},
			6, {`RESP_ACK, 8'h19, 8'h03, 24'hA55AC3});
		// Level query reports the pins, not the level setting
		add_row(0, 4, {`CMD_GPIO_QUERY, 8'h1A, 8'h01, `SEL_LEVEL, 24'h0},
			6, {`RESP_ACK, 8'h1A, 8'h03, pins});
		add_row(1, 1, {8'h1B, 48'h0}, 3, {`RESP_NAK, 8'h1B, 8'h00, 24'h0});
		add_row(0, 4, {`CMD_I2C_QUERY, 8'h1C, 8'h01, 8'h78, 24'h0},
			3, {`RESP_NAK, 8'h1C, 8'h00, 24'h0});
		// Unknown command gets no reply
		add_row(0, 4, {8'h7A, 8'h1D, 8'h01, `SEL_SPEED, 24'h0}, 0, 48'h0);
		add_row(0, 5, {`CMD_VERSION, 8'h1E, 8'h02, 8'h00, 8'h04, 16'h0},
			3, {`RESP_ACK, 8'h1E, 8'h00, 24'h0});
		add_row(0, 7, {`CMD_GPIO_SET, 8'h1F, 8'h04, `SEL_SPEED, 24'h112233},
			3, {`RESP_NAK, 8'h1F, 8'h00, 24'h0});
	endtask

	task automatic send_request(input int r);
		if (row_nak[r]) begin
			@(posedge clk);
			generate_nak <= 1'b1;
			@(posedge clk);
			generate_nak <= 1'b0;
		end
		for (int i = 0; i < req_count[r]; i++) begin
			@(posedge clk);
			ma_frame_valid <= !row_nak[r];
			ma_data_valid <= 1'b1;
			ma_data <= req_bytes[r][55 - 8 * i -: 8];
		end
		@(posedge clk);
		ma_frame_valid <= 1'b0;
		ma_data_valid <= 1'b0;
	endtask

	task automatic wait_response();
		int n;
		n = 0;
		@(negedge clk);
		while (!sl_arb_request) begin
			n++;
			if (n > RESP_WAIT)
				stop_run("no response frame was committed in time");
			@(negedge clk);
		end
	endtask

	task automatic expect_silence();
		repeat (SILENT_CYCLES) begin
			@(negedge clk);
			compare_value("sl_arb_request", sl_arb_request, 32'h0);
		end
	endtask

	// Read data follows the address by one cycle
	task automatic read_entry(input basics_proto_pkg::fifo_ptr_t addr,
		output basics_proto_pkg::fifo_entry_t data);
		@(posedge clk);
		sl_addr <= addr;
		@(posedge clk);
		@(negedge clk);
		data = sl_data;
	endtask

	task automatic check_frame(input int r);
		basics_proto_pkg::fifo_ptr_t   count;
		basics_proto_pkg::fifo_ptr_t   addr;
		basics_proto_pkg::fifo_entry_t entry;
		count = sl_tail - rd_ptr;
		compare_value("sl_tail - read pointer", count, rsp_count[r]);
		for (int i = 0; i < rsp_count[r]; i++) begin
			addr = rd_ptr + basics_proto_pkg::fifo_ptr_t'(i);
			read_entry(addr, entry);
			compare_value($sformatf("sl_data byte %0d", i), entry[7:0],
				rsp_bytes[r][47 - 8 * i -: 8]);
			compare_value($sformatf("sl_data end flag %0d", i), entry[8],
				i == rsp_count[r] - 1);
		end
	endtask

	task automatic release_frame();
		@(posedge clk);
		sl_latch_tail <= 1'b1;
		@(posedge clk);
		sl_latch_tail <= 1'b0;
	endtask

	task automatic check_settings(input int r);
		compare_value("i2c_speed", i2c_speed, exp_speed[r]);
		compare_value("i2c_addr", i2c_addr, exp_addr[r]);
		compare_value("gpio_level", gpio_level, exp_level[r]);
		compare_value("gpio_direction", gpio_direction, exp_dir[r]);
	endtask

	task automatic run_row(input int r);
		logic [23:0] level_before;
		logic [23:0] dir_before;
		level_before = (r == 0) ? 24'h0 : exp_level[r - 1];
		dir_before = (r == 0) ? 24'h0 : exp_dir[r - 1];
		@(posedge clk);
		gpio_read <= row_pins[r];
		send_request(r);
		if (rsp_count[r] == 0) begin
			expect_silence();
		end else begin
			wait_response();
			// GPIO outputs hold their old words until the reply is released
			compare_value("gpio_level", gpio_level, level_before);
			compare_value("gpio_direction", gpio_direction, dir_before);
			check_frame(r);
			release_frame();
			rd_ptr = rd_ptr + basics_proto_pkg::fifo_ptr_t'(rsp_count[r]);
		end
		repeat (SETTLE_CYCLES) @(posedge clk);
		@(negedge clk);
		check_settings(r);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		generate_nak = 1'b0;
		ma_data = '0;
		ma_data_valid = 1'b0;
		ma_frame_valid = 1'b0;
		sl_addr = '0;
		sl_latch_tail = 1'b0;
		gpio_read = '0;
		rd_ptr = '0;
		row_total = 0;
		table_ready = 1'b0;
		void'($urandom(1413));
		build_table();
		table_ready = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		compare_value("sl_arb_request", sl_arb_request, 32'h0);
		compare_value("sl_tail", sl_tail, 32'h0);
		compare_value("i2c_speed", i2c_speed, 32'd99);
		compare_value("i2c_addr", i2c_addr, 32'hFFFF);
		compare_value("gpio_level", gpio_level, 32'h0);
		compare_value("gpio_direction", gpio_direction, 32'h0);
		for (int r = 0; r < row_total; r++)
			run_row(r);
		$display("All checks passed");
		$finish;
	end

	// Generous bound of 200 cycles per row
	initial begin
		wait (table_ready);
		#(CLK_PERIOD * 200 * row_total);
		stop_run("watchdog expired before all rows were run");
	end

endmodule

`default_nettype wire
